//--- src/dmm_settings.svh
/*
  widths, bit positions, register addresses and phase lengths of the DMM control FPGA.
  the phase lengths assume a 20 MHz clk.
*/
`ifndef DMM_SETTINGS_SVH
`define DMM_SETTINGS_SVH

// conditioning vector, 4x4 mux bits + 8 monitor + 5 singles
`define NUM_BITS            29
`define IDX_AZMUX           0
`define IDX_HIMUX           4
`define IDX_HIMUX2          8
`define IDX_SIG_PC_SW       12
`define IDX_LED0            13
`define IDX_MONITOR         14
`define IDX_ADCMUX          22
`define IDX_CMPR_LATCH      26
`define IDX_MEAS_COMPLETE   27
`define IDX_SPI_INTERRUPT   28

// spi frame and register bank
`define REG_WIDTH           32
`define ADDR_WIDTH          7
`define SPI_CMD_BITS        8
`define SPI_FRAME_BITS      40
`define ADDR_ROUTE          7'd1
`define ADDR_MODE           7'd2
`define ADDR_DIRECT         7'd3
`define ADDR_DIRECT2        7'd4

// clk cycles per phase, 10 Hz and 1 kHz
`define ALT_DIV_DEFAULT     2000000
`define AZ_DIV_DEFAULT      20000
// az mux on LO, enable bit set
`define AZ_ZERO_SEL         4'b1011

`endif

//--- src/cond_pkg.sv
/*
  types of the conditioning output vector and the mode register.
  only the low three bits of the mode register select a source.
*/
`include "dmm_settings.svh"

package cond_pkg;

  // whole conditioning vector, see IDX_ macros for the field layout
  typedef logic [`NUM_BITS-1:0] out_vec_t;

  // one analog mux control, {en, a2, a1, a0}
  typedef logic [3:0] mux4_t;

  typedef enum logic [2:0] {
    MODE_ZERO    = 3'd0,
    MODE_ONES    = 3'd1,
    MODE_COUNT   = 3'd2,
    MODE_DIRECT  = 3'd3,
    MODE_ALT     = 3'd4,
    MODE_AZ      = 3'd5,
    MODE_UNUSED6 = 3'd6,
    MODE_UNUSED7 = 3'd7
  } mode_t;

endpackage

//--- src/spi_pkg.sv
/*
  types of the SPI frame and the register bank.
  frame is 8 command bits then 32 data bits, MSB first.
*/
`include "dmm_settings.svh"

package spi_pkg;

  // one bank register
  typedef logic [`REG_WIDTH-1:0] reg_word_t;

  // command byte low bits, bit 7 is the write flag
  typedef logic [`ADDR_WIDTH-1:0] reg_addr_t;

  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_CMD,
    SPI_DATA
  } spi_state_t;

endpackage

//--- src/spi_reg_bank.sv
/*
  SPI slave, mode 0, pins oversampled by clk through two-flop synchronizers.
  sck must stay below about clk/6 so every edge is seen.
  writes commit on cs release only after exactly 40 bits; unknown addresses read zero.
*/
`include "dmm_settings.svh"

module spi_reg_bank
  import spi_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      spi_sck,
  input  logic      spi_cs,
  input  logic      spi_mosi,
  output reg_word_t route,
  output reg_word_t mode,
  output reg_word_t direct,
  output reg_word_t direct2,
  output logic      reg_miso
);

  ////////////////////
  // pin synchronizers
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;

  logic       sck_rise;
  logic       sck_fall;
  logic       cs_fall;
  logic       cs_rise;
  logic       mosi_s;

  spi_state_t state;
  logic [5:0] bit_cnt;
  logic       wr_flag;
  reg_addr_t  addr;
  reg_addr_t  next_addr;
  reg_word_t  shift_in;
  reg_word_t  rd_shift;
  reg_word_t  read_word;

  // stage 2 against stage 3 gives the edges
  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];
  assign mosi_s   = mosi_q[1];

  // address as it completes on the last command bit
  assign next_addr = {shift_in[5:0], mosi_s};
  assign reg_miso  = rd_shift[31];

  always_comb
  begin
    case (next_addr)
      `ADDR_ROUTE:   read_word = route;
      `ADDR_MODE:    read_word = mode;
      `ADDR_DIRECT:  read_word = direct;
      `ADDR_DIRECT2: read_word = direct2;
      default:       read_word = '0;
    endcase
  end

  // receive shifter, command bits pass through it too
  always_ff @(posedge clk)
  begin
    if (state != SPI_IDLE && sck_rise)
      shift_in <= {shift_in[30:0], mosi_s};
  end

  ////////////////////
  // frame FSM and registers
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sck_q    <= 3'b000;
      cs_q     <= 3'b111;
      mosi_q   <= 2'b00;
      state    <= SPI_IDLE;
      bit_cnt  <= '0;
      wr_flag  <= 1'b0;
      addr     <= '0;
      rd_shift <= '0;
      route    <= '0;
      mode     <= '0;
      direct   <= '0;
      direct2  <= '0;
    end
    else
    begin
      sck_q  <= {sck_q[1:0], spi_sck};
      cs_q   <= {cs_q[1:0], spi_cs};
      mosi_q <= {mosi_q[0], spi_mosi};
      case (state)
        SPI_IDLE:
        begin
          if (cs_fall)
          begin
            state   <= SPI_CMD;
            bit_cnt <= '0;
          end
        end
        SPI_CMD:
        begin
          if (cs_rise)
            state <= SPI_IDLE;
          else if (sck_rise)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            // eighth bit closes the command byte
            if (bit_cnt == 6'(`SPI_CMD_BITS - 1))
            begin
              wr_flag  <= shift_in[6];
              addr     <= next_addr;
              rd_shift <= read_word;
              state    <= SPI_DATA;
            end
          end
        end
        SPI_DATA:
        begin
          if (cs_rise)
          begin
            state <= SPI_IDLE;
            if (wr_flag && bit_cnt == 6'(`SPI_FRAME_BITS))
            begin
              case (addr)
                `ADDR_ROUTE:   route   <= shift_in;
                `ADDR_MODE:    mode    <= shift_in;
                `ADDR_DIRECT:  direct  <= shift_in;
                `ADDR_DIRECT2: direct2 <= shift_in;
                default:       ;
              endcase
            end
          end
          else if (sck_rise)
          begin
            // saturate so an overlong frame never wraps back to 40
            if (bit_cnt != 6'h3f)
              bit_cnt <= bit_cnt + 1'b1;
          end
          // hold bit 31 across the fall that ends the command byte
          else if (sck_fall && bit_cnt > 6'(`SPI_CMD_BITS))
            rd_shift <= {rd_shift[30:0], 1'b0};
        end
        default:
          state <= SPI_IDLE;
      endcase
    end
  end

endmodule

//--- src/spi_4094_route.sv
/*
  pin to pin route of the SPI lines to the 4094 chain, no clk involved.
  routing needs route[0] set and spi_cs2 low; the 4094 strobe is active high.
*/

module spi_4094_route (
  input  logic       spi_sck,
  input  logic       spi_cs2,
  input  logic       spi_mosi,
  input  logic       u1004_4094_data,
  input  logic       reg_miso,
  input  logic [1:0] route,
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe,
  output logic       oe_4094,
  output logic       spi_miso
);

  logic route_act;

  // chain selected and enabled by the mcu
  assign route_act = route[0] & ~spi_cs2;

  // lines held low when not routed
  assign glb_4094_clk    = route_act & spi_sck;
  assign glb_4094_data   = route_act & spi_mosi;
  assign glb_4094_strobe = route_act;

  // output enable of the 4094 outputs, left to the mcu
  assign oe_4094 = route[1];

  // chain return while routed, else the register bank
  assign spi_miso = route_act ? u1004_4094_data : reg_miso;

endmodule

//--- src/pattern_gen.sv
/*
  test patterns for modes 2 and 4.
  ALT_DIV must be 2 or more; alt_out shows direct2 first, after one full period.
*/

module pattern_gen
  import cond_pkg::*;
#(
  parameter int ALT_DIV = 16
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  out_vec_t direct,
  input  out_vec_t direct2,
  output out_vec_t count_out,
  output out_vec_t alt_out
);

  localparam int DIV_W = $clog2(ALT_DIV);

  logic [DIV_W-1:0] phase_cnt;
  logic             alt_state;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count_out <= '0;
      phase_cnt <= '0;
      alt_state <= 1'b0;
      alt_out   <= '0;
    end
    else
    begin
      // free running, wraps mod 2^29
      count_out <= count_out + 1'b1;
      phase_cnt <= phase_cnt + 1'b1;
      if (phase_cnt == DIV_W'(ALT_DIV - 1))
      begin
        phase_cnt <= '0;
        alt_state <= ~alt_state;
        // state 0 is the direct phase, so its end loads direct2
        if (alt_state)
          alt_out <= direct;
        else
          alt_out <= direct2;
      end
    end
  end

endmodule

//--- src/az_modulator.sv
/*
  auto-zero sequencer, signal and zero phases of AZ_DIV clk cycles each.
  AZ_DIV must be 2 or more. starts in the signal phase after reset.
*/
`include "dmm_settings.svh"

module az_modulator
  import cond_pkg::*;
#(
  parameter int AZ_DIV = 10
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  mux4_t      az_sig_sel,
  output logic       sig_pc_sw,
  output logic       led0,
  output mux4_t      azmux,
  output logic [7:0] monitor
);

  localparam int DIV_W = $clog2(AZ_DIV);

  logic [DIV_W-1:0] phase_cnt;
  logic             zero_phase;
  logic             phase_pulse;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      phase_cnt   <= '0;
      zero_phase  <= 1'b0;
      phase_pulse <= 1'b0;
    end
    else
    begin
      phase_cnt   <= phase_cnt + 1'b1;
      phase_pulse <= 1'b0;
      if (phase_cnt == DIV_W'(AZ_DIV - 1))
      begin
        phase_cnt   <= '0;
        zero_phase  <= ~zero_phase;
        // high in the first cycle of the new phase
        phase_pulse <= 1'b1;
      end
    end
  end

  // precharge closed while the az mux reads the signal
  assign sig_pc_sw = ~zero_phase;
  assign azmux     = zero_phase ? `AZ_ZERO_SEL : az_sig_sel;
  assign led0      = sig_pc_sw;
  assign monitor   = {6'b000000, phase_pulse, zero_phase};

endmodule

//--- src/conditioning_ctl.sv
/*
  mode select of the conditioning vector, registered once.
  only mode[2:0] counts; codes 6 and 7 drive zeros.
*/
`include "dmm_settings.svh"

module conditioning_ctl
  import cond_pkg::*;
  import spi_pkg::*;
#(
  parameter int ALT_DIV = `ALT_DIV_DEFAULT,
  parameter int AZ_DIV  = `AZ_DIV_DEFAULT
)
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_word_t mode,
  input  reg_word_t direct,
  input  reg_word_t direct2,
  output out_vec_t  cond_out
);

  out_vec_t   count_out;
  out_vec_t   alt_out;
  out_vec_t   az_vec;
  mode_t      mode_sel;
  logic       az_pc_sw;
  logic       az_led0;
  mux4_t      az_azmux;
  logic [7:0] az_monitor;

  pattern_gen #(.ALT_DIV(ALT_DIV)) u_pattern (
    .clk       (clk),
    .rst_n     (rst_n),
    .direct    (direct[`NUM_BITS-1:0]),
    .direct2   (direct2[`NUM_BITS-1:0]),
    .count_out (count_out),
    .alt_out   (alt_out)
  );

  // the signal phase uses the az mux code held in direct
  az_modulator #(.AZ_DIV(AZ_DIV)) u_az (
    .clk        (clk),
    .rst_n      (rst_n),
    .az_sig_sel (direct[`IDX_AZMUX +: 4]),
    .sig_pc_sw  (az_pc_sw),
    .led0       (az_led0),
    .azmux      (az_azmux),
    .monitor    (az_monitor)
  );

  ////////////////////
  // mode 5 vector
  // himux, himux2, adc switches and the top bits stay with direct
  always_comb
  begin
    az_vec                       = direct[`NUM_BITS-1:0];
    az_vec[`IDX_AZMUX +: 4]      = az_azmux;
    az_vec[`IDX_SIG_PC_SW]       = az_pc_sw;
    az_vec[`IDX_LED0]            = az_led0;
    az_vec[`IDX_MONITOR +: 8]    = az_monitor;
  end

  assign mode_sel = mode_t'(mode[2:0]);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cond_out <= '0;
    else
    begin
      case (mode_sel)
        MODE_ZERO:    cond_out <= '0;
        MODE_ONES:    cond_out <= '1;
        MODE_COUNT:   cond_out <= count_out;
        MODE_DIRECT:  cond_out <= direct[`NUM_BITS-1:0];
        MODE_ALT:     cond_out <= alt_out;
        MODE_AZ:      cond_out <= az_vec;
        MODE_UNUSED6: cond_out <= '0;
        MODE_UNUSED7: cond_out <= '0;
        default:      cond_out <= '0;
      endcase
    end
  end

endmodule

//--- src/dmm_top.sv
/*
  DMM front end control FPGA top; SPI register bank, 4094 route and conditioning outputs.
  spi_cs selects the register bank, spi_cs2 the 4094 chain; both active low.
*/
`include "dmm_settings.svh"

module dmm_top
  import cond_pkg::*;
  import spi_pkg::*;
#(
  parameter int ALT_DIV = `ALT_DIV_DEFAULT,
  parameter int AZ_DIV  = `AZ_DIV_DEFAULT
)
(
  input  logic clk, rst_n,
  input  logic spi_sck, spi_cs, spi_cs2, spi_mosi, u1004_4094_data,
  output logic spi_miso,
  output logic glb_4094_clk, glb_4094_data, glb_4094_strobe, oe_4094,
  output mux4_t azmux, himux, himux2, adcmux,
  output logic [7:0] monitor,
  output logic sig_pc_sw, led0, cmpr_latch, meas_complete, spi_interrupt
);

  reg_word_t route, mode, direct, direct2;
  logic      reg_miso;
  out_vec_t  cond_out;

  spi_reg_bank u_regs (
    .clk (clk), .rst_n (rst_n),
    .spi_sck (spi_sck), .spi_cs (spi_cs), .spi_mosi (spi_mosi),
    .route (route), .mode (mode), .direct (direct), .direct2 (direct2),
    .reg_miso (reg_miso)
  );

  spi_4094_route u_route (
    .spi_sck (spi_sck), .spi_cs2 (spi_cs2), .spi_mosi (spi_mosi),
    .u1004_4094_data (u1004_4094_data), .reg_miso (reg_miso), .route (route[1:0]),
    .glb_4094_clk (glb_4094_clk), .glb_4094_data (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe), .oe_4094 (oe_4094), .spi_miso (spi_miso)
  );

  conditioning_ctl #(.ALT_DIV(ALT_DIV), .AZ_DIV(AZ_DIV)) u_cond (
    .clk (clk), .rst_n (rst_n),
    .mode (mode), .direct (direct), .direct2 (direct2), .cond_out (cond_out)
  );

  // split the vector onto the board pins
  assign azmux         = cond_out[`IDX_AZMUX +: 4];
  assign himux         = cond_out[`IDX_HIMUX +: 4];
  assign himux2        = cond_out[`IDX_HIMUX2 +: 4];
  assign sig_pc_sw     = cond_out[`IDX_SIG_PC_SW];
  assign led0          = cond_out[`IDX_LED0];
  assign monitor       = cond_out[`IDX_MONITOR +: 8];
  assign adcmux        = cond_out[`IDX_ADCMUX +: 4];
  assign cmpr_latch    = cond_out[`IDX_CMPR_LATCH];
  assign meas_complete = cond_out[`IDX_MEAS_COMPLETE];
  assign spi_interrupt = cond_out[`IDX_SPI_INTERRUPT];

endmodule

//--- tests/tb_dmm_top.sv
/*
  testbench of dmm_top, built with ALT_DIV 16 and AZ_DIV 10 to keep the phases short.
  SPI is bit-banged at 16 clk cycles per sck period, well inside the oversampling limit.
  direct and direct2 words come from an xorshift generator with a fixed seed.
*/
`include "dmm_settings.svh"

module tb_dmm_top
  import cond_pkg::*;
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TB_ALT_DIV = 16;
  localparam int TB_AZ_DIV  = 10;
  localparam int SCK_HALF   = 8;
  localparam int FRAME_CYCLES = 2 * SCK_HALF * `SPI_FRAME_BITS + 3 * SCK_HALF;
  localparam int NUM_ROWS   = 10;
  localparam logic [31:0] SEED = 32'h306f_241b;

  typedef enum logic [1:0] {
    KIND_STATIC,
    KIND_COUNT,
    KIND_ALT,
    KIND_AZ
  } kind_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       spi_sck;
  logic       spi_cs;
  logic       spi_cs2;
  logic       spi_mosi;
  logic       u1004_4094_data;
  logic       spi_miso;
  logic       glb_4094_clk;
  logic       glb_4094_data;
  logic       glb_4094_strobe;
  logic       oe_4094;
  mux4_t      azmux;
  mux4_t      himux;
  mux4_t      himux2;
  mux4_t      adcmux;
  logic [7:0] monitor;
  logic       sig_pc_sw;
  logic       led0;
  logic       cmpr_latch;
  logic       meas_complete;
  logic       spi_interrupt;

  // stimulus table with one row per mode test
  reg_word_t   mode_tbl    [NUM_ROWS];
  reg_word_t   direct_tbl  [NUM_ROWS];
  reg_word_t   direct2_tbl [NUM_ROWS];
  kind_t       kind_tbl    [NUM_ROWS];

  logic [31:0] rng;
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          test_err_base = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 0;

  dmm_top #(.ALT_DIV(TB_ALT_DIV), .AZ_DIV(TB_AZ_DIV)) dut0 (
    .clk (clk), .rst_n (rst_n),
    .spi_sck (spi_sck), .spi_cs (spi_cs), .spi_cs2 (spi_cs2), .spi_mosi (spi_mosi),
    .u1004_4094_data (u1004_4094_data), .spi_miso (spi_miso),
    .glb_4094_clk (glb_4094_clk), .glb_4094_data (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe), .oe_4094 (oe_4094),
    .azmux (azmux), .himux (himux), .himux2 (himux2), .adcmux (adcmux),
    .monitor (monitor), .sig_pc_sw (sig_pc_sw), .led0 (led0), .cmpr_latch (cmpr_latch),
    .meas_complete (meas_complete), .spi_interrupt (spi_interrupt)
  );

  // 4 ns period
  always #2 clk = ~clk;

  ////////////////////
  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit)
    begin
      $display("timeout: the run was still going after %0d clk cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // output pins put back together in vector order
  function automatic out_vec_t pins();
    return {spi_interrupt, meas_complete, cmpr_latch, adcmux, monitor,
            led0, sig_pc_sw, himux2, himux, azmux};
  endfunction

  // expected vector of the modes that hold still
  function automatic out_vec_t expected_static(input reg_word_t m, input reg_word_t d);
    case (m[2:0])
      3'd1:    return '1;
      3'd3:    return d[`NUM_BITS-1:0];
      default: return '0;
    endcase
  endfunction

  function automatic int kind_window(input kind_t k);
    case (k)
      KIND_COUNT: return 40;
      KIND_ALT:   return 64;
      KIND_AZ:    return 32;
      default:    return 8;
    endcase
  endfunction

  // reset, readback, table rows and route test
  function automatic int run_cycles();
    int total;
    total = 16 + 9 * FRAME_CYCLES;
    for (int i = 0; i < NUM_ROWS; i++)
      total += 3 * FRAME_CYCLES + kind_window(kind_tbl[i]) + 40;
    total += FRAME_CYCLES + 40;
    return total;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      $display("Fail %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_cnt++;
    test_err_base = err_cnt;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic set_row(input int idx, input reg_word_t m, input kind_t k);
    mode_tbl[idx] = m;
    kind_tbl[idx] = k;
    rng = xorshift(rng);
    direct_tbl[idx] = rng;
    rng = xorshift(rng);
    direct2_tbl[idx] = rng;
  endtask

  ////////////////////
  // SPI master in mode 0
  // mosi changes with the falling sck and miso is taken just before the rise
  task automatic spi_frame(input logic [7:0] cmd, input reg_word_t wdata,
                           output reg_word_t rdata);
    logic [39:0] frame;
    frame = {cmd, wdata};
    rdata = '0;
    @(posedge clk);
    spi_cs <= 1'b0;
    for (int i = 39; i >= 0; i--)
    begin
      spi_mosi <= frame[i];
      wait_cycles(SCK_HALF - 1);
      @(negedge clk);
      if (i < 32)
        rdata[i] = spi_miso;
      @(posedge clk);
      spi_sck <= 1'b1;
      wait_cycles(SCK_HALF);
      spi_sck <= 1'b0;
    end
    wait_cycles(SCK_HALF);
    spi_cs   <= 1'b1;
    spi_mosi <= 1'b0;
    // commit and output register settle well inside this gap
    wait_cycles(SCK_HALF);
  endtask

  task automatic spi_write(input reg_addr_t addr, input reg_word_t data);
    reg_word_t unused;
    spi_frame({1'b1, addr}, data, unused);
  endtask

  task automatic spi_read(input reg_addr_t addr, output reg_word_t data);
    spi_frame({1'b0, addr}, '0, data);
  endtask

  ////////////////////
  // tests
  task automatic readback_test();
    reg_addr_t addrs [4];
    reg_word_t words [4];
    reg_word_t rd;
    addrs[0] = `ADDR_ROUTE;
    addrs[1] = `ADDR_MODE;
    addrs[2] = `ADDR_DIRECT;
    addrs[3] = `ADDR_DIRECT2;
    // all writes first, so each read also shows the others left it alone
    for (int i = 0; i < 4; i++)
    begin
      rng = xorshift(rng);
      words[i] = rng;
      spi_write(addrs[i], words[i]);
    end
    for (int i = 0; i < 4; i++)
    begin
      spi_read(addrs[i], rd);
      compare($sformatf("reg %0d readback", addrs[i]), rd, words[i]);
    end
    spi_read(7'h55, rd);
    compare("unknown reg readback", rd, 32'h0);
    report_test("register readback");
  endtask

  task automatic apply_row(input int idx);
    reg_word_t m;
    reg_word_t d;
    reg_word_t d2;
    out_vec_t  a;
    out_vec_t  s;
    out_vec_t  last;
    mux4_t     exp_az;
    int        k;
    int        run;
    int        changes;
    logic      seen_d;
    logic      seen_d2;
    logic      last_pc;
    m  = mode_tbl[idx];
    d  = direct_tbl[idx];
    d2 = direct2_tbl[idx];
    spi_write(`ADDR_DIRECT, d);
    spi_write(`ADDR_DIRECT2, d2);
    spi_write(`ADDR_MODE, m);
    case (kind_tbl[idx])
      KIND_STATIC:
      begin
        @(negedge clk);
        compare("cond pins", pins(), expected_static(m, d));
      end
      KIND_COUNT:
      begin
        for (int j = 0; j < 2; j++)
        begin
          @(negedge clk);
          a = pins();
          rng = xorshift(rng);
          k = int'(rng[3:0]) + 1;
          repeat (k) @(negedge clk);
          // wraps at 29 bits
          s = a + out_vec_t'(k);
          compare("count pins", pins(), s);
        end
      end
      KIND_ALT:
      begin
        seen_d  = 1'b0;
        seen_d2 = 1'b0;
        run     = 0;
        last    = '0;
        for (int i = 0; i < 64; i++)
        begin
          @(negedge clk);
          s = pins();
          check_cnt++;
          if (s !== d[`NUM_BITS-1:0] && s !== d2[`NUM_BITS-1:0])
          begin
            $display("Fail cond pins: %h is neither direct %h nor direct2 %h",
                     s, d[`NUM_BITS-1:0], d2[`NUM_BITS-1:0]);
            err_cnt++;
          end
          if (s === d[`NUM_BITS-1:0])
            seen_d = 1'b1;
          if (s === d2[`NUM_BITS-1:0])
            seen_d2 = 1'b1;
          if (i > 0 && s === last)
            run++;
          else
            run = 1;
          // report a stuck value once
          if (run == TB_ALT_DIV + 1)
          begin
            $display("alternation held one value for more than %0d cycles", TB_ALT_DIV);
            err_cnt++;
          end
          last = s;
        end
        check_cnt++;
        if (!seen_d || !seen_d2)
        begin
          $display("alternation did not show both direct and direct2 within 64 cycles");
          err_cnt++;
        end
      end
      KIND_AZ:
      begin
        changes = 0;
        last_pc = 1'b0;
        for (int i = 0; i < 32; i++)
        begin
          @(negedge clk);
          compare("himux", himux, d[`IDX_HIMUX +: 4]);
          compare("himux2", himux2, d[`IDX_HIMUX2 +: 4]);
          compare("adcmux", adcmux, d[`IDX_ADCMUX +: 4]);
          compare("upper bits", {spi_interrupt, meas_complete, cmpr_latch},
                  d[`IDX_CMPR_LATCH +: 3]);
          exp_az = sig_pc_sw ? d[`IDX_AZMUX +: 4] : `AZ_ZERO_SEL;
          compare("azmux", azmux, exp_az);
          compare("led0", led0, sig_pc_sw);
          // bit 0 flags the zero phase and bit 1 pulses on each phase change
          compare("monitor[0]", monitor[0], !sig_pc_sw);
          if (i > 0)
            compare("monitor[1]", monitor[1], sig_pc_sw !== last_pc);
          compare("monitor[7:2]", monitor[7:2], 6'h00);
          if (i > 0 && sig_pc_sw !== last_pc)
            changes++;
          last_pc = sig_pc_sw;
        end
        check_cnt++;
        if (changes == 0)
        begin
          $display("sig_pc_sw never changed within 32 cycles of auto-zero mode");
          err_cnt++;
        end
      end
      default:
      begin
        $display("table row %0d has no check kind", idx);
        err_cnt++;
      end
    endcase
    report_test($sformatf("mode %0d", m[2:0]));
  endtask

  task automatic route_test();
    logic sck_v;
    logic mosi_v;
    logic ret_v;
    spi_write(`ADDR_ROUTE, 32'h0000_0003);
    @(negedge clk);
    compare("oe_4094", oe_4094, 1'b1);
    for (int i = 0; i < 8; i++)
    begin
      rng = xorshift(rng);
      sck_v  = rng[0];
      mosi_v = rng[1];
      ret_v  = rng[2];
      @(posedge clk);
      spi_cs2         <= 1'b0;
      spi_sck         <= sck_v;
      spi_mosi        <= mosi_v;
      u1004_4094_data <= ret_v;
      @(negedge clk);
      compare("glb_4094_clk", glb_4094_clk, sck_v);
      compare("glb_4094_data", glb_4094_data, mosi_v);
      compare("glb_4094_strobe", glb_4094_strobe, 1'b1);
      compare("spi_miso", spi_miso, ret_v);
    end
    // deselected chain sees nothing even with the pins high
    @(posedge clk);
    spi_cs2  <= 1'b1;
    spi_sck  <= 1'b1;
    spi_mosi <= 1'b1;
    @(negedge clk);
    compare("glb_4094_clk", glb_4094_clk, 1'b0);
    compare("glb_4094_data", glb_4094_data, 1'b0);
    compare("glb_4094_strobe", glb_4094_strobe, 1'b0);
    @(posedge clk);
    spi_sck  <= 1'b0;
    spi_mosi <= 1'b0;
    report_test("4094 route");
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    rst_n           = 1'b0;
    spi_sck         = 1'b0;
    spi_cs          = 1'b1;
    spi_cs2         = 1'b1;
    spi_mosi        = 1'b0;
    u1004_4094_data = 1'b0;
    rng             = SEED;

    set_row(0, 32'h0000_0000, KIND_STATIC);
    set_row(1, 32'h0000_0001, KIND_STATIC);
    set_row(2, 32'h0000_0003, KIND_STATIC);
    set_row(3, 32'h0000_0006, KIND_STATIC);
    set_row(4, 32'h0000_0007, KIND_STATIC);
    set_row(5, 32'h0000_0002, KIND_COUNT);
    set_row(6, 32'h0000_0004, KIND_ALT);
    set_row(7, 32'h0000_0005, KIND_AZ);
    // upper mode bits are ignored
    set_row(8, 32'h0000_00f9, KIND_STATIC);
    set_row(9, 32'h0000_0003, KIND_STATIC);
    timeout_limit = 20 * run_cycles();

    wait_cycles(8);
    rst_n <= 1'b1;
    @(negedge clk);
    compare("cond pins", pins(), '0);
    compare("oe_4094", oe_4094, 1'b0);
    compare("glb_4094_strobe", glb_4094_strobe, 1'b0);
    report_test("reset state");

    readback_test();
    for (int i = 0; i < NUM_ROWS; i++)
      apply_row(i);
    route_test();

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/cond_pkg.sv
src/spi_pkg.sv
src/spi_reg_bank.sv
src/spi_4094_route.sv
src/pattern_gen.sv
src/az_modulator.sv
src/conditioning_ctl.sv
src/dmm_top.sv
tests/tb_dmm_top.sv
